// ==== vlog.f ====
+incdir+src
src/udp_tx_pkg.sv
src/udp_header_gen.sv
src/crc32_d8.sv
src/gmii_frame_tx.sv
src/udp_tx.sv
bench/tb_udp_tx.sv

// ==== bench/tb_udp_tx.sv ====
`include "udp_tx_defs.svh"

module tb_udp_tx;
    timeunit 1ns;
    timeprecision 1ps;

    logic                 clk = 1'b0;
    logic                 rst_n = 1'b0;
    logic                 tx_start_en = 1'b0;
    logic [15:0]          tx_byte_num = 16'd0;
    logic [31:0]          tx_data = 32'd0;
    logic                 arb_grant = 1'b0;
    logic                 timestamp_rst = 1'b0;
    logic                 arb_req;
    logic                 tx_req;
    logic                 tx_done;
    logic                 gmii_tx_en;
    logic [7:0]           gmii_txd;
    udp_tx_pkg::net_cfg_t cfg = '{48'h0a1b2c3d4e5f, 48'h021122334455, 32'hc0a80002, 32'hc0a80001};

    integer      seed = 32'hc8749659;
    logic [7:0]  frame_q[$];   // bytes seen while gmii_tx_en is high
    logic [31:0] word_q[$];    // payload words served
    logic [31:0] next_word;
    logic        hold_grant = 1'b0;
    int          grant_wait = 3;
    int          done_cnt = 0;
    int          done_at_rst = 0;
    int          frames_sent = 0;
    int          exp_ts = 0;
    int          errors = 0;
    int          errors_at_start = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    udp_tx udp_tx_inst (
        .clk(clk), .rst_n(rst_n), .tx_start_en(tx_start_en), .tx_byte_num(tx_byte_num),
        .tx_data(tx_data), .cfg(cfg), .arb_grant(arb_grant), .timestamp_rst(timestamp_rst),
        .arb_req(arb_req), .tx_req(tx_req), .tx_done(tx_done), .gmii_tx_en(gmii_tx_en),
        .gmii_txd(gmii_txd)
    );

    always #10 clk = ~clk;

    // ****************************************
    // payload source, arbiter, capture
    // ****************************************

    always @(posedge clk) begin
        if (tx_req) begin
            next_word = $random(seed);
            tx_data <= next_word;    // valid before the second edge
            word_q.push_back(next_word);
        end
    end

    always @(posedge clk) begin
        if (tx_done) begin
            arb_grant <= 1'b0;
        end else if (arb_req && !arb_grant && !hold_grant) begin
            if (grant_wait == 0) begin
                arb_grant  <= 1'b1;
                grant_wait <= {$random(seed)} % 8;
            end else begin
                grant_wait <= grant_wait - 1;
            end
        end
    end

    always @(posedge clk) begin
        if (gmii_tx_en) begin
            frame_q.push_back(gmii_txd);
        end
        if (tx_done) begin
            done_cnt <= done_cnt + 1;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(arb_req && gmii_tx_en)) else begin
        $display("arb_req and gmii_tx_en were high in the same cycle");
        errors++;
    end

    assert property (@(posedge clk) disable iff (!rst_n) !arb_grant |-> !gmii_tx_en) else begin
        $display("gmii_tx_en was high without arb_grant");
        errors++;
    end

    // one cycle pulse right after the last fcs byte
    assert property (@(posedge clk) disable iff (!rst_n) tx_done == $fell(gmii_tx_en)) else begin
        $display("tx_done did not pulse for one cycle right after the end of the frame");
        errors++;
    end

    // ****************************************
    // helpers
    // ****************************************

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            $display("Mismatch %s: expected %0h, actual %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic finish_test(input string tname);
        tests_run++;
        if (errors != errors_at_start) begin
            tests_failed++;
        end
        $display("test %-10s %s", tname, (errors == errors_at_start) ? "ok" : "FAILED");
        errors_at_start = errors;
    endtask

    task automatic abort_run(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Some tests failed");
        $finish;
    endtask

    // captured bytes, first one most significant
    function automatic logic [63:0] field(input int first, input int count);
        logic [63:0] v;
        v = 64'd0;
        for (int i = 0; i < count; i++) begin
            v = {v[55:0], frame_q[first + i]};
        end
        return v;
    endfunction

    // ones' complement sum over the ip header, checksum field as zero
    function automatic logic [15:0] ip_checksum();
        logic [31:0] s;
        s = 32'd0;
        for (int i = 22; i < 42; i += 2) begin
            if (i != 32) begin
                s = s + {16'd0, frame_q[i], frame_q[i + 1]};
            end
        end
        s = s[15:0] + s[31:16];
        s = s[15:0] + s[31:16];
        return ~s[15:0];
    endfunction

    function automatic logic [31:0] eth_crc(input int first, input int count);
        logic [31:0] c;
        c = 32'hffff_ffff;
        for (int i = first; i < first + count; i++) begin
            c = c ^ {24'd0, frame_q[i]};
            for (int b = 0; b < 8; b++) begin
                c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);  // reflected poly
            end
        end
        return ~c;
    endfunction

    task automatic start_frame(input int n);
        frame_q.delete();
        word_q.delete();
        @(posedge clk);
        exp_ts = done_cnt - done_at_rst;  // last tx_done counted by now
        tx_byte_num <= n[15:0];
        tx_start_en <= 1'b1;
        @(posedge clk);
        tx_start_en <= 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!tx_done && n < 2000) begin
            @(posedge clk);
            n++;
        end
        if (!tx_done) begin
            abort_run("tx_done");
        end
    endtask

    task automatic check_frame(input string tname, input int n);
        int          pad;
        logic [31:0] c;
        logic [7:0]  exp_byte;
        pad = (n < `UDP_MIN_USER_BYTES) ? `UDP_MIN_USER_BYTES : n;
        check_value({tname, " tx_en cycles"}, 58 + pad, frame_q.size());
        check_value({tname, " payload words"}, (n + 3) / 4, word_q.size());
        if (frame_q.size() == 58 + pad && word_q.size() == (n + 3) / 4) begin
            check_value({tname, " preamble"}, {{7{`UDP_PREAMBLE_BYTE}}, `UDP_SFD_BYTE}, field(0, 8));
            check_value({tname, " dst_mac"}, cfg.dst_mac, field(8, 6));
            check_value({tname, " src_mac"}, cfg.src_mac, field(14, 6));
            check_value({tname, " ether type"}, `UDP_ETH_TYPE, field(20, 2));
            check_value({tname, " ip total len"}, {16'h4500, 16'(n + 32)}, field(22, 4));
            check_value({tname, " ip id"}, {16'(frames_sent + 1), 16'h4000}, field(26, 4));
            check_value({tname, " ttl proto"}, 16'h4011, field(30, 2));     // 64, udp
            check_value({tname, " ip checksum"}, ip_checksum(), field(32, 2));
            check_value({tname, " ip addrs"}, {cfg.src_ip, cfg.dst_ip}, field(34, 8));
            check_value({tname, " udp ports"},
                        {`UDP_SRC_PORT, 16'(`UDP_DST_PORT_MIN + frames_sent % 6)}, field(42, 4));
            check_value({tname, " udp len"}, {16'(n + 12), 16'h0000}, field(46, 4));
            check_value({tname, " timestamp"}, exp_ts, field(50, 4));
            for (int i = 0; i < pad; i++) begin
                exp_byte = (i < n) ? word_q[i / 4][8 * (3 - i % 4) +: 8] : 8'h00;
                check_value({tname, " payload byte"}, exp_byte, frame_q[54 + i]);
            end
            c = eth_crc(8, 46 + pad);
            check_value({tname, " fcs"}, {c[7:0], c[15:8], c[23:16], c[31:24]}, field(54 + pad, 4));
        end
        frames_sent++;
    endtask

    task automatic run_frame(input string tname, input int n);
        start_frame(n);
        wait_done();
        check_frame(tname, n);
    endtask

    // ****************************************
    // test sequence
    // ****************************************

    initial begin
        int n;
        hold_grant <= 1'b1;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_value("reset_arb outputs", 12'h000, {arb_req, tx_req, gmii_tx_en, tx_done, gmii_txd});
        start_frame(40);
        n = 0;
        while (!arb_req && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (!arb_req) begin
            abort_run("arb_req");
        end
        repeat (20) begin
            @(posedge clk);
            check_value("reset_arb req held", 2'b10, {arb_req, gmii_tx_en});
        end
        hold_grant <= 1'b0;
        wait_done();
        finish_test("reset_arb");
        check_frame("frame_40", 40);
        finish_test("frame_40");
        run_frame("frame_6", 6);                 // padded to the minimum
        finish_test("frame_6");
        for (int k = 0; k < 8; k++) begin
            run_frame("counters", 1 + {$random(seed)} % 48);
        end
        @(posedge clk);
        timestamp_rst <= 1'b1;
        done_at_rst = done_cnt;
        @(posedge clk);
        timestamp_rst <= 1'b0;
        run_frame("counters", 20);               // timestamp back at zero
        finish_test("counters");
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== src/udp_tx.sv ====
module udp_tx (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  tx_start_en,
    input  logic [15:0]           tx_byte_num,
    input  logic [31:0]           tx_data,
    input  udp_tx_pkg::net_cfg_t  cfg,
    input  logic                  arb_grant,
    input  logic                  timestamp_rst,
    output logic                  arb_req,
    output logic                  tx_req,
    output logic                  tx_done,
    output logic                  gmii_tx_en,
    output logic [7:0]            gmii_txd
);

    udp_tx_pkg::hdr_words_t hdr;
    logic                   hdr_valid;
    logic                   hdr_load;
    logic                   frame_done;
    logic                   crc_clr;
    logic                   crc_en;
    logic [7:0]             crc_byte;
    logic [31:0]            crc_state;
    logic [31:0]            crc_next;

    // ip / udp header words and checksum
    udp_header_gen udp_header_gen_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .hdr_load      (hdr_load),
        .frame_done    (frame_done),
        .timestamp_rst (timestamp_rst),
        .tx_byte_num   (tx_byte_num),
        .cfg           (cfg),
        .hdr           (hdr),
        .hdr_valid     (hdr_valid)
    );

    crc32_d8 crc32_d8_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .crc_clr   (crc_clr),
        .crc_en    (crc_en),
        .crc_byte  (crc_byte),
        .crc_state (crc_state),
        .crc_next  (crc_next)
    );

    gmii_frame_tx gmii_frame_tx_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .tx_start_en (tx_start_en),
        .tx_byte_num (tx_byte_num),
        .tx_data     (tx_data),
        .cfg         (cfg),
        .arb_grant   (arb_grant),
        .hdr         (hdr),
        .hdr_valid   (hdr_valid),
        .crc_state   (crc_state),
        .crc_next    (crc_next),
        .arb_req     (arb_req),
        .tx_req      (tx_req),
        .hdr_load    (hdr_load),
        .frame_done  (frame_done),
        .tx_done     (tx_done),
        .crc_clr     (crc_clr),
        .crc_en      (crc_en),
        .gmii_tx_en  (gmii_tx_en),
        .crc_byte    (crc_byte),
        .gmii_txd    (gmii_txd)
    );

endmodule

// ==== src/gmii_frame_tx.sv ====
`include "udp_tx_defs.svh"

module gmii_frame_tx (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    tx_start_en,
    input  logic [15:0]             tx_byte_num,
    input  logic [31:0]             tx_data,
    input  udp_tx_pkg::net_cfg_t    cfg,
    input  logic                    arb_grant,
    input  udp_tx_pkg::hdr_words_t  hdr,
    input  logic                    hdr_valid,
    input  logic [31:0]             crc_state,
    input  logic [31:0]             crc_next,
    output logic                    arb_req,
    output logic                    tx_req,
    output logic                    hdr_load,
    output logic                    frame_done,
    output logic                    tx_done,
    output logic                    crc_clr,
    output logic                    crc_en,
    output logic                    gmii_tx_en,
    output logic [7:0]              crc_byte,
    output logic [7:0]              gmii_txd
);

    udp_tx_pkg::tx_state_e state;

    logic         start_d0;
    logic         start_d1;
    logic         start_pos;
    logic [4:0]   cnt;        // byte index in preamble, eth, ip and fcs
    logic [15:0]  pay_cnt;    // byte index in payload incl. padding
    logic [15:0]  tx_num;     // user bytes of this frame
    logic [15:0]  pad_len;    // user bytes after padding
    logic         fcs_last;
    logic [111:0] eth_hdr;

    assign start_pos = start_d0 & ~start_d1;
    assign eth_hdr   = {cfg.dst_mac, cfg.src_mac, `UDP_ETH_TYPE};

    // crc follows the registered output byte
    assign crc_byte   = gmii_txd;
    assign crc_clr    = tx_done;
    assign frame_done = tx_done;

    // fcs goes out inverted and bit reversed
    function automatic logic [7:0] fcs_byte(input logic [7:0] c);
        logic [7:0] r;
        for (int i = 0; i < 8; i++) begin
            r[i] = ~c[7 - i];
        end
        return r;
    endfunction

    // ****************************************
    // transmit fsm
    // ****************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= udp_tx_pkg::st_idle;
            start_d0   <= 1'b0;
            start_d1   <= 1'b0;
            cnt        <= 5'd0;
            pay_cnt    <= 16'd0;
            tx_num     <= 16'd0;
            pad_len    <= 16'd0;
            fcs_last   <= 1'b0;
            arb_req    <= 1'b0;
            tx_req     <= 1'b0;
            hdr_load   <= 1'b0;
            tx_done    <= 1'b0;
            crc_en     <= 1'b0;
            gmii_tx_en <= 1'b0;
            gmii_txd   <= 8'd0;
        end else begin
            start_d0   <= tx_start_en;
            start_d1   <= start_d0;
            hdr_load   <= 1'b0;
            tx_req     <= 1'b0;
            crc_en     <= 1'b0;
            gmii_tx_en <= 1'b0;
            gmii_txd   <= 8'd0;    // also the pad byte
            fcs_last   <= 1'b0;
            tx_done    <= fcs_last;

            case (state)
                udp_tx_pkg::st_idle: begin
                    if (start_pos) begin
                        tx_num   <= tx_byte_num;
                        pad_len  <= (tx_byte_num >= `UDP_MIN_USER_BYTES) ?
                                    tx_byte_num : `UDP_MIN_USER_BYTES;
                        hdr_load <= 1'b1;
                        arb_req  <= 1'b1;
                        state    <= udp_tx_pkg::st_arb;
                    end
                end

                udp_tx_pkg::st_arb: begin
                    // hdr_valid is stale while hdr_load is still high
                    if (arb_grant && hdr_valid && !hdr_load) begin
                        arb_req    <= 1'b0;
                        gmii_tx_en <= 1'b1;
                        gmii_txd   <= `UDP_PREAMBLE_BYTE;
                        cnt        <= 5'd1;
                        state      <= udp_tx_pkg::st_preamble;
                    end
                end

                udp_tx_pkg::st_preamble: begin
                    gmii_tx_en <= 1'b1;
                    if (cnt == 5'd7) begin
                        gmii_txd <= `UDP_SFD_BYTE;
                        cnt      <= 5'd0;
                        state    <= udp_tx_pkg::st_eth_head;
                    end else begin
                        gmii_txd <= `UDP_PREAMBLE_BYTE;
                        cnt      <= cnt + 5'd1;
                    end
                end

                udp_tx_pkg::st_eth_head: begin
                    gmii_tx_en <= 1'b1;
                    crc_en     <= 1'b1;
                    gmii_txd   <= eth_hdr[8 * (5'd13 - cnt) +: 8];
                    if (cnt == 5'd13) begin
                        cnt   <= 5'd0;
                        state <= udp_tx_pkg::st_ip_head;
                    end else begin
                        cnt <= cnt + 5'd1;
                    end
                end

                udp_tx_pkg::st_ip_head: begin
                    gmii_tx_en <= 1'b1;
                    crc_en     <= 1'b1;
                    gmii_txd   <= hdr[cnt[4:2]].bytes[2'd3 - cnt[1:0]];
                    if (cnt == 5'd30 && tx_num != 16'd0) begin
                        tx_req <= 1'b1;  // first payload word, early
                    end
                    if (cnt == 5'd31) begin
                        cnt     <= 5'd0;
                        pay_cnt <= 16'd0;
                        state   <= udp_tx_pkg::st_payload;
                    end else begin
                        cnt <= cnt + 5'd1;
                    end
                end

                udp_tx_pkg::st_payload: begin
                    gmii_tx_en <= 1'b1;
                    crc_en     <= 1'b1;
                    if (pay_cnt < tx_num) begin
                        gmii_txd <= tx_data[8 * (2'd3 - pay_cnt[1:0]) +: 8];
                    end
                    // next word only if it holds a user byte
                    if (pay_cnt[1:0] == 2'd2 && ({1'b0, pay_cnt} + 17'd2) < {1'b0, tx_num}) begin
                        tx_req <= 1'b1;
                    end
                    if (pay_cnt == pad_len - 16'd1) begin
                        pay_cnt <= 16'd0;
                        cnt     <= 5'd0;
                        state   <= udp_tx_pkg::st_fcs;
                    end else begin
                        pay_cnt <= pay_cnt + 16'd1;
                    end
                end

                udp_tx_pkg::st_fcs: begin
                    gmii_tx_en <= 1'b1;
                    case (cnt[1:0])
                        2'd0:    gmii_txd <= fcs_byte(crc_next[31:24]);  // last pad byte in flight
                        2'd1:    gmii_txd <= fcs_byte(crc_state[23:16]);
                        2'd2:    gmii_txd <= fcs_byte(crc_state[15:8]);
                        default: gmii_txd <= fcs_byte(crc_state[7:0]);
                    endcase
                    if (cnt == 5'd3) begin
                        cnt      <= 5'd0;
                        fcs_last <= 1'b1;
                        state    <= udp_tx_pkg::st_idle;
                    end else begin
                        cnt <= cnt + 5'd1;
                    end
                end

                default: state <= udp_tx_pkg::st_idle;
            endcase
        end
    end

endmodule

// ==== src/crc32_d8.sv ====
module crc32_d8 (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        crc_clr,
    input  logic        crc_en,
    input  logic [7:0]  crc_byte,
    output logic [31:0] crc_state,
    output logic [31:0] crc_next
);

    localparam logic [31:0] POLY = 32'h04c11db7;

    // one byte through the shift register, lsb first
    function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] d);
        logic [31:0] r;
        logic        fb;
        r = c;
        for (int i = 0; i < 8; i++) begin
            fb = r[31] ^ d[i];
            r  = {r[30:0], 1'b0};
            if (fb) begin
                r = r ^ POLY;
            end
        end
        return r;
    endfunction

    assign crc_next = crc_step(crc_state, crc_byte);  // includes current byte

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_state <= 32'hffff_ffff;
        end else if (crc_clr) begin
            crc_state <= 32'hffff_ffff;   // ready for next frame
        end else if (crc_en) begin
            crc_state <= crc_next;
        end
    end

endmodule

// ==== src/udp_header_gen.sv ====
`include "udp_tx_defs.svh"

module udp_header_gen (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    hdr_load,
    input  logic                    frame_done,
    input  logic                    timestamp_rst,
    input  logic [15:0]             tx_byte_num,
    input  udp_tx_pkg::net_cfg_t    cfg,
    output udp_tx_pkg::hdr_words_t  hdr,
    output logic                    hdr_valid
);

    logic [15:0] ip_id;        // identification of the last frame built
    logic [15:0] dst_port;     // port for the next frame
    logic [31:0] frame_cnt;    // timestamp source
    logic [2:0]  stage;        // checksum pipeline, one hot per step
    logic [19:0] hdr_sum;      // sum of the ten ip header halves
    logic [19:0] csum;         // running checksum
    logic [15:0] ip_len;
    logic [15:0] udp_len;
    logic [15:0] ip_id_nxt;

    assign ip_len    = tx_byte_num + `UDP_IP_HDR_BYTES + `UDP_UDP_HDR_BYTES + `UDP_TS_BYTES;
    assign udp_len   = tx_byte_num + `UDP_UDP_HDR_BYTES + `UDP_TS_BYTES;
    assign ip_id_nxt = ip_id + 16'd1;

    // ****************************************
    // per-frame counters
    // ****************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ip_id    <= 16'd0;
            dst_port <= `UDP_DST_PORT_MIN;
        end else if (hdr_load) begin
            ip_id <= ip_id_nxt;
            if (dst_port < `UDP_DST_PORT_MAX) begin
                dst_port <= dst_port + 16'd1;
            end else begin
                dst_port <= `UDP_DST_PORT_MIN;  // wrap
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_cnt <= 32'd0;
        end else if (timestamp_rst) begin
            frame_cnt <= 32'd0;
        end else if (frame_done) begin
            frame_cnt <= frame_cnt + 32'd1;
        end
    end

    // ****************************************
    // header words
    // ****************************************

    always_ff @(posedge clk) begin
        if (hdr_load) begin
            hdr[0] <= {8'h45, 8'h00, ip_len};          // version, ihl, tos, total len
            hdr[1] <= {ip_id_nxt, 16'h4000};           // don't fragment
            hdr[2] <= {8'd64, 8'd17, 16'h0000};        // ttl, udp, checksum later
            hdr[3] <= cfg.src_ip;
            hdr[4] <= cfg.dst_ip;
            hdr[5] <= {`UDP_SRC_PORT, dst_port};
            hdr[6] <= {udp_len, 16'h0000};             // udp checksum unused
            hdr[7] <= frame_cnt;
        end else if (stage[2]) begin
            hdr[2].halves[0] <= ~(csum[15:0] + {15'd0, csum[16]});
        end
    end

    // ten halves of the ip header, checksum field still zero
    always_comb begin
        hdr_sum = 20'd0;
        for (int i = 0; i < 5; i++) begin
            hdr_sum = hdr_sum + hdr[i].halves[1] + hdr[i].halves[0];
        end
    end

    // ****************************************
    // checksum pipeline
    // ****************************************

    always_ff @(posedge clk) begin
        if (stage[0]) begin
            csum <= hdr_sum;
        end else if (stage[1]) begin
            csum <= {4'd0, csum[15:0]} + {16'd0, csum[19:16]};  // first fold
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage     <= 3'b000;
            hdr_valid <= 1'b0;
        end else begin
            stage <= {stage[1:0], hdr_load};
            if (hdr_load) begin
                hdr_valid <= 1'b0;
            end else if (stage[2]) begin
                hdr_valid <= 1'b1;  // second fold and invert land now
            end
        end
    end

endmodule

// ==== src/udp_tx_pkg.sv ====
package udp_tx_pkg;

    // ****************************************
    // header word views
    // ****************************************

    // one 32-bit header word
    // checksum adds the 16-bit halves, serializer walks the bytes
    typedef union packed {
        logic [1:0][15:0] halves;  // [1] is the upper half
        logic [3:0][7:0]  bytes;   // [3] goes on the wire first
    } hdr_word_u;

    // words 0..4 ip header, 5..6 udp header, 7 timestamp
    typedef hdr_word_u [7:0] hdr_words_t;

    // ****************************************
    // addressing
    // ****************************************

    typedef struct packed {
        logic [47:0] dst_mac;
        logic [47:0] src_mac;
        logic [31:0] dst_ip;
        logic [31:0] src_ip;
    } net_cfg_t;

    // ****************************************
    // transmit fsm
    // ****************************************

    typedef enum logic [2:0] {
        st_idle,      // wait for start edge
        st_arb,       // request gmii port
        st_preamble,  // 7 x 55 + d5
        st_eth_head,  // macs and ether type
        st_ip_head,   // ip + udp + timestamp words
        st_payload,   // user data then zero pad
        st_fcs        // crc bytes
    } tx_state_e;

endpackage

// ==== src/udp_tx_defs.svh ====
`ifndef UDP_TX_DEFS_SVH
`define UDP_TX_DEFS_SVH

// ****************************************
// ethernet / ip / udp frame constants
// ****************************************

`define UDP_ETH_TYPE        16'h0800   // ipv4
`define UDP_SRC_PORT        16'd1234
`define UDP_DST_PORT_MIN    16'd1234   // rotation start
`define UDP_DST_PORT_MAX    16'd1239   // rotation end, then wrap

// 46 byte min eth payload less ip, udp and timestamp
`define UDP_MIN_USER_BYTES  16'd14

`define UDP_IP_HDR_BYTES    16'd20
`define UDP_UDP_HDR_BYTES   16'd8
`define UDP_TS_BYTES        16'd4

// preamble is 7 of these, then the sfd
`define UDP_PREAMBLE_BYTE   8'h55
`define UDP_SFD_BYTE        8'hd5

`endif
